// ==== tb.f ====
hw/dd_pkg.sv
hw/stream_slice.sv
hw/cmd_decoder.sv
hw/config_capture.sv
hw/dram_writer.sv
hw/status_arbiter.sv
hw/d_domain_top.sv
verification/d_domain_chk.sv
verification/tb_d_domain.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the d_domain testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_d_domain -f tb.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/Vtb_d_domain
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit $sim_status
fi
exit 0

// ==== verification/tb_d_domain.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_d_domain import dd_pkg::*; ();

    logic         ui_clk;
    logic         rst;
    logic         calib_done;
    logic         p2d_cmd_valid;
    logic         p2d_cmd_ready;
    cmd_word_t    p2d_cmd;
    logic         p2d_data_valid;
    logic         p2d_data_ready;
    dram_word_t   p2d_data;
    logic         a2d_cmd_valid;
    logic         a2d_cmd_ready;
    cmd_word_t    a2d_cmd;
    logic         d2p_cmd_valid;
    logic         d2p_cmd_ready = 1'b0;
    cmd_word_t    d2p_cmd;
    logic         d2a_cmd_valid;
    logic         d2a_cmd_ready = 1'b0;
    cmd_word_t    d2a_cmd;
    logic         app_rdy = 1'b0;
    logic         app_wdf_rdy = 1'b0;
    app_write_t   app_req;
    asic_config_t asic_config;

    logic [15:0]  lfsr = 16'd18;
    logic [15:0]  bp_lfsr = 16'd18;
    cmd_word_t    exp_d2p[$];
    cmd_word_t    exp_d2a[$];
    app_write_t   exp_app[$];
    int           d2p_seen = 0;
    int           d2a_seen = 0;
    int           app_seen = 0;
    int           cfg_cnt = 0;
    logic [31:0]  win_base;
    logic [31:0]  win_last;
    int           wr_k;

    d_domain_top u_d_domain_top (
        .ui_clk         (ui_clk),
        .rst            (rst),
        .p2d_cmd_valid  (p2d_cmd_valid),
        .p2d_cmd_ready  (p2d_cmd_ready),
        .p2d_cmd        (p2d_cmd),
        .p2d_data_valid (p2d_data_valid),
        .p2d_data_ready (p2d_data_ready),
        .p2d_data       (p2d_data),
        .a2d_cmd_valid  (a2d_cmd_valid),
        .a2d_cmd_ready  (a2d_cmd_ready),
        .a2d_cmd        (a2d_cmd),
        .calib_done     (calib_done),
        .app_rdy        (app_rdy),
        .app_wdf_rdy    (app_wdf_rdy),
        .d2p_cmd_valid  (d2p_cmd_valid),
        .d2p_cmd_ready  (d2p_cmd_ready),
        .d2p_cmd        (d2p_cmd),
        .d2a_cmd_valid  (d2a_cmd_valid),
        .d2a_cmd_ready  (d2a_cmd_ready),
        .d2a_cmd        (d2a_cmd),
        .app_req        (app_req),
        .asic_config    (asic_config)
    );

    initial begin
        ui_clk = 1'b0;
        forever #10 ui_clk = ~ui_clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [255:0] rand_bits(input int n);
        logic [255:0] v;
        int           i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[254:0], lfsr[0]};
        end
        return v;
    endfunction

    // high about three times in four
    function automatic logic rand_ready();
        logic a;
        bp_lfsr = lfsr_step(bp_lfsr);
        a = bp_lfsr[0];
        bp_lfsr = lfsr_step(bp_lfsr);
        return a | bp_lfsr[0];
    endfunction

    function automatic cmd_word_t make_cmd(input logic [OPCODE_W-1:0] op,
                                           input logic [PAYLOAD_W-1:0] pay);
        cmd_word_t w;
        w.opcode = op;
        w.payload = pay;
        return w;
    endfunction

    function automatic logic outstanding();
        return d2p_seen != exp_d2p.size() || d2a_seen != exp_d2a.size()
            || app_seen != exp_app.size();
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal;
    endtask

    task automatic check_eq(input string name, input logic [511:0] exp,
                            input logic [511:0] act);
        assert (exp == act) else begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
            $display("Test failed");
            $fatal;
        end
    endtask

    // processor, accelerator and controller back-pressure
    always @(negedge ui_clk) begin
        d2p_cmd_ready = rand_ready();
        d2a_cmd_ready = rand_ready();
        app_rdy = rand_ready();
        app_wdf_rdy = rand_ready();
    end

    always @(posedge ui_clk) begin
        if (!rst) begin
            if (d2p_cmd_valid && d2p_cmd_ready) begin
                if (d2p_seen >= exp_d2p.size()) begin
                    fail_now("unexpected report on d2p");
                end else begin
                    check_eq("d2p_order", 512'(exp_d2p[d2p_seen]), 512'(d2p_cmd));
                    d2p_seen++;
                end
            end
            if (d2a_cmd_valid && d2a_cmd_ready) begin
                if (d2a_seen >= exp_d2a.size()) begin
                    fail_now("unexpected word on d2a");
                end else begin
                    check_eq("d2a_order", 512'(exp_d2a[d2a_seen]), 512'(d2a_cmd));
                    d2a_seen++;
                end
            end
            if (app_req.en) begin
                if (app_seen >= exp_app.size()) begin
                    fail_now("unexpected write request on app_req");
                end else begin
                    check_eq("app_req", 512'(exp_app[app_seen]), 512'(app_req));
                    app_seen++;
                end
            end
            if (p2d_cmd_valid && p2d_cmd_ready && p2d_cmd.opcode == OP_CONFIG
                    && cfg_cnt < CONFIG_WORDS) begin
                cfg_cnt++;
            end
            // training done may only pass after a full sequence
            if (a2d_cmd_valid && a2d_cmd_ready && a2d_cmd.opcode == OP_TRAIN_DONE) begin
                check_eq("train_gate", 512'(CONFIG_WORDS), 512'(cfg_cnt));
                cfg_cnt = 0;
            end
        end
    end

    task automatic idle_gap();
        repeat (int'(rand_bits(2))) @(negedge ui_clk);
    endtask

    task automatic send_cmd(input cmd_word_t w);
        int n;
        n = 0;
        idle_gap();
        p2d_cmd = w;
        p2d_cmd_valid = 1'b1;
        @(posedge ui_clk);
        while (!p2d_cmd_ready && n < 5000) begin
            @(posedge ui_clk);
            n++;
        end
        if (!p2d_cmd_ready) fail_now("p2d command was never accepted");
        @(negedge ui_clk);
        p2d_cmd_valid = 1'b0;
    endtask

    task automatic offer_a2d(input cmd_word_t w);
        int n;
        n = 0;
        idle_gap();
        a2d_cmd = w;
        a2d_cmd_valid = 1'b1;
        @(posedge ui_clk);
        while (!a2d_cmd_ready && n < 5000) begin
            @(posedge ui_clk);
            n++;
        end
        if (!a2d_cmd_ready) fail_now("a2d command was never accepted");
        @(negedge ui_clk);
        a2d_cmd_valid = 1'b0;
    endtask

    task automatic write_word(input dram_word_t d);
        app_write_t r;
        int         cnt;
        int         n;
        r = '0;
        r.en = 1'b1;
        r.cmd = APP_CMD_WRITE;
        r.addr = APP_ADDR_W'(win_base + 32'(ADDR_STEP * wr_k));
        r.wdf_wren = 1'b1;
        r.wdf_data = d;
        r.wdf_end = 1'b1;
        exp_app.push_back(r);
        wr_k++;
        cnt = ADDR_STEP * wr_k;
        if (32'(r.addr) == win_last) begin
            exp_d2p.push_back(make_cmd(OP_WRITE_DONE, '0));
        end else if (cnt % PROGRESS_STEP == 0) begin
            exp_d2p.push_back(make_cmd(OP_PROGRESS, PAYLOAD_W'(cnt)));
        end
        n = 0;
        idle_gap();
        p2d_data = d;
        p2d_data_valid = 1'b1;
        @(posedge ui_clk);
        while (!p2d_data_ready && n < 5000) begin
            @(posedge ui_clk);
            n++;
        end
        if (!p2d_data_ready) fail_now("p2d data word was never accepted");
        @(negedge ui_clk);
        p2d_data_valid = 1'b0;
    endtask

    task automatic set_window(input logic [31:0] base, input logic [31:0] last);
        win_base = base;
        win_last = last;
        wr_k = 0;
        send_cmd(make_cmd(OP_WINDOW, {1'b0, base[15:0]}));
        send_cmd(make_cmd(OP_WINDOW, {1'b0, base[31:16]}));
        send_cmd(make_cmd(OP_WINDOW, {1'b0, last[15:0]}));
        send_cmd(make_cmd(OP_WINDOW, {1'b0, last[31:16]}));
    endtask

    // words 1 to 9 give the stored fields, low payload bits
    task automatic run_config_seq(output asic_config_t c);
        cmd_word_t w;
        int        i;
        c = '0;
        for (i = 0; i < CONFIG_WORDS; i++) begin
            w = make_cmd(OP_CONFIG, PAYLOAD_W'(rand_bits(PAYLOAD_W)));
            case (i)
                0: c.asic_mode = w.payload[1:0];
                1: c.training_epochs = w.payload[15:0];
                2: c.inference_epochs = w.payload[15:0];
                3: c.dataset = w.payload[1:0];
                4: c.timesteps = w.payload[15:0];
                5: c.input_size = w.payload[15:0];
                6: c.long_streaming = w.payload[0];
                7: c.binary_classifier = w.payload[0];
                8: c.loser_encourage = w.payload[0];
                default: ;
            endcase
            exp_d2a.push_back(w);
            send_cmd(w);
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (outstanding() && n < 3000) begin
            @(negedge ui_clk);
            n++;
        end
        if (outstanding()) fail_now("expected outputs did not arrive in time");
    endtask

    initial begin
        int           n;
        asic_config_t c;
        cmd_word_t    td;
        rst = 1'b1;
        calib_done = 1'b0;
        p2d_cmd_valid = 1'b0;
        p2d_cmd = '0;
        p2d_data_valid = 1'b0;
        p2d_data = '0;
        a2d_cmd_valid = 1'b0;
        a2d_cmd = '0;
        win_base = '0;
        win_last = '0;
        wr_k = 0;
        repeat (3) @(posedge ui_clk);
        @(negedge ui_clk);
        check_eq("reset_d2p_valid", '0, 512'(d2p_cmd_valid));
        check_eq("reset_d2a_valid", '0, 512'(d2a_cmd_valid));
        check_eq("reset_app_en", '0, 512'(app_req.en));
        check_eq("reset_data_ready", '0, 512'(p2d_data_ready));
        check_eq("reset_asic_config", '0, 512'(asic_config));
        rst = 1'b0;

        // dram ready, once
        exp_d2p.push_back(make_cmd(OP_DRAM_READY, '0));
        calib_done = 1'b1;
        n = 0;
        while (!d2p_cmd_valid && n < 4) begin
            @(negedge ui_clk);
            n++;
        end
        if (!d2p_cmd_valid) fail_now("dram ready report not raised within 4 cycles");
        wait_drained();

        // unknown opcodes are dropped on both inputs
        send_cmd(make_cmd(15'd9, 17'h1abcd));
        offer_a2d(make_cmd(15'd7, 17'h00042));

        td = make_cmd(OP_TRAIN_DONE, PAYLOAD_W'(rand_bits(PAYLOAD_W)));
        exp_d2p.push_back(td);
        fork
            offer_a2d(td);
            run_config_seq(c);
        join
        wait_drained();
        check_eq("asic_config_1", 512'(c), 512'(asic_config));

        // second training done waits for a fresh sequence
        td = make_cmd(OP_TRAIN_DONE, PAYLOAD_W'(rand_bits(PAYLOAD_W)));
        exp_d2p.push_back(td);
        fork
            offer_a2d(td);
            begin
                repeat (30) @(negedge ui_clk);
                run_config_seq(c);
            end
        join
        wait_drained();
        check_eq("asic_config_2", 512'(c), 512'(asic_config));

        set_window(32'h0012_3400, 32'h0FFF_FFF8);
        for (n = 0; n < 40; n++) write_word(rand_bits(DRAM_DATA_W));
        wait_drained();

        // 1300 words, progress at 1250 and finish at the last
        set_window(32'h0040_0000, 32'h0040_0000 + 32'(ADDR_STEP * 1299));
        for (n = 0; n < 1300; n++) write_word(rand_bits(DRAM_DATA_W));
        wait_drained();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/d_domain_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module d_domain_chk import dd_pkg::*; (
    input logic       ui_clk,
    input logic       rst,
    input logic       d2p_cmd_valid,
    input logic       d2p_cmd_ready,
    input cmd_word_t  d2p_cmd,
    input logic       d2a_cmd_valid,
    input logic       d2a_cmd_ready,
    input cmd_word_t  d2a_cmd,
    input app_write_t app_req
);

    // stalled streams hold valid and payload
    d2p_hold: assert property (@(posedge ui_clk) disable iff (rst)
        d2p_cmd_valid && !d2p_cmd_ready |=> d2p_cmd_valid && $stable(d2p_cmd))
        else $error("d2p report changed while stalled");

    d2a_hold: assert property (@(posedge ui_clk) disable iff (rst)
        d2a_cmd_valid && !d2a_cmd_ready |=> d2a_cmd_valid && $stable(d2a_cmd))
        else $error("d2a word changed while stalled");

    req_data: assert property (@(posedge ui_clk) disable iff (rst)
        app_req.en |-> app_req.wdf_wren && app_req.wdf_end)
        else $error("write request without its data strobes");

    req_cmd: assert property (@(posedge ui_clk) disable iff (rst)
        app_req.en |-> app_req.cmd == APP_CMD_WRITE)
        else $error("write request with a non-write command");

    // idle request carries nothing
    req_idle: assert property (@(posedge ui_clk) disable iff (rst)
        !app_req.en |-> app_req == '0)
        else $error("app_req fields set while en is low");

endmodule

bind d_domain_top d_domain_chk u_d_domain_chk (
    .ui_clk        (ui_clk),
    .rst           (rst),
    .d2p_cmd_valid (d2p_cmd_valid),
    .d2p_cmd_ready (d2p_cmd_ready),
    .d2p_cmd       (d2p_cmd),
    .d2a_cmd_valid (d2a_cmd_valid),
    .d2a_cmd_ready (d2a_cmd_ready),
    .d2a_cmd       (d2a_cmd),
    .app_req       (app_req)
);

`default_nettype wire

// ==== hw/d_domain_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module d_domain_top import dd_pkg::*; (
    input  logic         ui_clk,
    input  logic         rst,
    input  logic         p2d_cmd_valid,
    output logic         p2d_cmd_ready,
    input  cmd_word_t    p2d_cmd,
    input  logic         p2d_data_valid,
    output logic         p2d_data_ready,
    input  dram_word_t   p2d_data,
    input  logic         a2d_cmd_valid,
    output logic         a2d_cmd_ready,
    input  cmd_word_t    a2d_cmd,
    input  logic         calib_done,
    input  logic         app_rdy,
    input  logic         app_wdf_rdy,
    output logic         d2p_cmd_valid,
    input  logic         d2p_cmd_ready,
    output cmd_word_t    d2p_cmd,
    output logic         d2a_cmd_valid,
    input  logic         d2a_cmd_ready,
    output cmd_word_t    d2a_cmd,
    output app_write_t   app_req,
    output asic_config_t asic_config
);

    logic                 cfg_valid;
    logic                 cfg_ready;
    logic                 win_valid;
    logic [PAYLOAD_W-1:0] win_payload;
    logic                 done_valid;
    logic                 done_ready;
    cmd_word_t            done_cmd;
    logic                 event_valid;
    logic                 event_ready;
    cmd_word_t            event_cmd;

    cmd_decoder u_cmd_decoder (
        .p2d_valid   (p2d_cmd_valid),
        .p2d_ready   (p2d_cmd_ready),
        .p2d_cmd     (p2d_cmd),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .win_valid   (win_valid),
        .win_payload (win_payload)
    );

    config_capture u_config_capture (
        .ui_clk      (ui_clk),
        .rst         (rst),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .cfg_cmd     (p2d_cmd),
        .d2a_valid   (d2a_cmd_valid),
        .d2a_ready   (d2a_cmd_ready),
        .d2a_cmd     (d2a_cmd),
        .a2d_valid   (a2d_cmd_valid),
        .a2d_ready   (a2d_cmd_ready),
        .a2d_cmd     (a2d_cmd),
        .done_valid  (done_valid),
        .done_ready  (done_ready),
        .done_cmd    (done_cmd),
        .asic_config (asic_config)
    );

    dram_writer u_dram_writer (
        .ui_clk      (ui_clk),
        .rst         (rst),
        .win_valid   (win_valid),
        .win_payload (win_payload),
        .data_valid  (p2d_data_valid),
        .data_ready  (p2d_data_ready),
        .data        (p2d_data),
        .app_rdy     (app_rdy),
        .app_wdf_rdy (app_wdf_rdy),
        .app_req     (app_req),
        .event_valid (event_valid),
        .event_ready (event_ready),
        .event_cmd   (event_cmd)
    );

    status_arbiter u_status_arbiter (
        .ui_clk      (ui_clk),
        .rst         (rst),
        .calib_done  (calib_done),
        .done_valid  (done_valid),
        .done_ready  (done_ready),
        .done_cmd    (done_cmd),
        .event_valid (event_valid),
        .event_ready (event_ready),
        .event_cmd   (event_cmd),
        .d2p_valid   (d2p_cmd_valid),
        .d2p_ready   (d2p_cmd_ready),
        .d2p_cmd     (d2p_cmd)
    );

endmodule

`default_nettype wire

// ==== hw/status_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_arbiter import dd_pkg::*; (
    input  logic      ui_clk,
    input  logic      rst,
    input  logic      calib_done,
    input  logic      done_valid,
    output logic      done_ready,
    input  cmd_word_t done_cmd,
    input  logic      event_valid,
    output logic      event_ready,
    input  cmd_word_t event_cmd,
    output logic      d2p_valid,
    input  logic      d2p_ready,
    output cmd_word_t d2p_cmd
);

    logic ready_sent;
    logic ready_due;
    logic load;

    always_comb begin
        ready_due = calib_done && !ready_sent;
        load      = !d2p_valid || d2p_ready;
    end

    // fixed priority: dram ready, training done, writer events
    always_comb begin
        done_ready  = load && !ready_due;
        event_ready = load && !ready_due && !done_valid;
    end

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            ready_sent <= 1'b0;
            d2p_valid  <= 1'b0;
        end else if (load) begin
            if (ready_due) begin
                d2p_valid       <= 1'b1;
                d2p_cmd.opcode  <= OP_DRAM_READY;
                d2p_cmd.payload <= '0;
                ready_sent      <= 1'b1;
            end else if (done_valid) begin
                d2p_valid <= 1'b1;
                d2p_cmd   <= done_cmd;
            end else if (event_valid) begin
                d2p_valid <= 1'b1;
                d2p_cmd   <= event_cmd;
            end else begin
                d2p_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/dram_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_writer import dd_pkg::*; (
    input  logic                 ui_clk,
    input  logic                 rst,
    input  logic                 win_valid,
    input  logic [PAYLOAD_W-1:0] win_payload,
    input  logic                 data_valid,
    output logic                 data_ready,
    input  dram_word_t           data,
    input  logic                 app_rdy,
    input  logic                 app_wdf_rdy,
    output app_write_t           app_req,
    output logic                 event_valid,
    input  logic                 event_ready,
    output cmd_word_t            event_cmd
);

    logic                  sl_valid;
    logic                  sl_ready;
    dram_word_t            sl_data;
    logic                  wr_fire;
    logic [WIN_ADDR_W-1:0] base_addr;
    logic [WIN_ADDR_W-1:0] last_addr;
    logic [1:0]            win_idx;
    logic [WIN_ADDR_W-1:0] write_count;
    logic [WIN_ADDR_W-1:0] next_count;
    logic [APP_ADDR_W-1:0] wr_addr;
    logic [PROG_CNT_W-1:0] prog_acc;
    logic [PROG_CNT_W-1:0] prog_next;
    logic                  prog_hit;
    logic                  last_hit;

    stream_slice #(
        .payload_t (dram_word_t)
    ) u_data_slice (
        .ui_clk    (ui_clk),
        .rst       (rst),
        .in_valid  (data_valid),
        .in_ready  (data_ready),
        .in_data   (data),
        .out_valid (sl_valid),
        .out_ready (sl_ready),
        .out_data  (sl_data)
    );

    always_comb begin
        sl_ready   = app_rdy && app_wdf_rdy && !event_valid;
        wr_fire    = sl_valid && sl_ready;
        wr_addr    = base_addr[APP_ADDR_W-1:0] + write_count[APP_ADDR_W-1:0];
        next_count = write_count + WIN_ADDR_W'(ADDR_STEP);
        last_hit   = (last_addr == WIN_ADDR_W'(wr_addr));
        // progress every PROGRESS_STEP of count, tracked without a divider
        prog_next  = prog_acc + PROG_CNT_W'(ADDR_STEP);
        prog_hit   = (prog_next == PROG_CNT_W'(PROGRESS_STEP));
    end

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            base_addr   <= '0;
            last_addr   <= '0;
            win_idx     <= '0;
            write_count <= '0;
            prog_acc    <= '0;
            event_valid <= 1'b0;
            app_req     <= '0;
        end else begin
            app_req <= '0;
            if (win_valid) begin
                case (win_idx)
                    2'd0: base_addr[15:0]  <= win_payload[15:0];
                    2'd1: base_addr[31:16] <= win_payload[15:0];
                    2'd2: last_addr[15:0]  <= win_payload[15:0];
                    default: last_addr[31:16] <= win_payload[15:0];
                endcase
                win_idx     <= win_idx + 1'b1;
                write_count <= '0;
                prog_acc    <= '0;
            end else if (wr_fire) begin
                write_count <= next_count;
                prog_acc    <= prog_hit ? '0 : prog_next;
            end
            if (wr_fire) begin
                app_req.en       <= 1'b1;
                app_req.cmd      <= APP_CMD_WRITE;
                app_req.addr     <= wr_addr;
                app_req.wdf_wren <= 1'b1;
                app_req.wdf_data <= sl_data;
                app_req.wdf_end  <= 1'b1;
                app_req.wdf_mask <= '0;
            end
            // finish wins over progress on the same word
            if (wr_fire && last_hit) begin
                event_valid       <= 1'b1;
                event_cmd.opcode  <= OP_WRITE_DONE;
                event_cmd.payload <= '0;
            end else if (wr_fire && prog_hit) begin
                event_valid       <= 1'b1;
                event_cmd.opcode  <= OP_PROGRESS;
                event_cmd.payload <= next_count[PAYLOAD_W-1:0];
            end else if (event_ready) begin
                event_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/config_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module config_capture import dd_pkg::*; (
    input  logic         ui_clk,
    input  logic         rst,
    input  logic         cfg_valid,
    output logic         cfg_ready,
    input  cmd_word_t    cfg_cmd,
    output logic         d2a_valid,
    input  logic         d2a_ready,
    output cmd_word_t    d2a_cmd,
    input  logic         a2d_valid,
    output logic         a2d_ready,
    input  cmd_word_t    a2d_cmd,
    output logic         done_valid,
    input  logic         done_ready,
    output cmd_word_t    done_cmd,
    output asic_config_t asic_config
);

    logic [CONFIG_CNT_W-1:0] cfg_count;
    logic                    cfg_fire;
    logic                    seq_full;
    logic                    is_done;

    stream_slice #(
        .payload_t (cmd_word_t)
    ) u_d2a_slice (
        .ui_clk    (ui_clk),
        .rst       (rst),
        .in_valid  (cfg_valid),
        .in_ready  (cfg_ready),
        .in_data   (cfg_cmd),
        .out_valid (d2a_valid),
        .out_ready (d2a_ready),
        .out_data  (d2a_cmd)
    );

    always_comb begin
        cfg_fire = cfg_valid && cfg_ready;
        seq_full = (cfg_count == CONFIG_CNT_W'(CONFIG_WORDS));
        is_done  = (a2d_cmd.opcode == OP_TRAIN_DONE);
    end

    // training done only goes out after a full sequence
    always_comb begin
        done_valid = a2d_valid && is_done && seq_full;
        done_cmd   = a2d_cmd;
        a2d_ready  = is_done ? (seq_full && done_ready) : 1'b1;
    end

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            cfg_count   <= '0;
            asic_config <= '0;
        end else begin
            if (done_valid && done_ready) begin
                cfg_count <= '0;
            end else if (cfg_fire && !seq_full) begin
                cfg_count <= cfg_count + 1'b1;
            end
            if (cfg_fire && cfg_count < CONFIG_CNT_W'(CONFIG_FIELDS)) begin
                case (cfg_count)
                    0: asic_config.asic_mode         <= cfg_cmd.payload[1:0];
                    1: asic_config.training_epochs   <= cfg_cmd.payload[15:0];
                    2: asic_config.inference_epochs  <= cfg_cmd.payload[15:0];
                    3: asic_config.dataset           <= cfg_cmd.payload[1:0];
                    4: asic_config.timesteps         <= cfg_cmd.payload[15:0];
                    5: asic_config.input_size        <= cfg_cmd.payload[15:0];
                    6: asic_config.long_streaming    <= cfg_cmd.payload[0];
                    7: asic_config.binary_classifier <= cfg_cmd.payload[0];
                    default: asic_config.loser_encourage <= cfg_cmd.payload[0];
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder import dd_pkg::*; (
    input  logic                 p2d_valid,
    output logic                 p2d_ready,
    input  cmd_word_t            p2d_cmd,
    output logic                 cfg_valid,
    input  logic                 cfg_ready,
    output logic                 win_valid,
    output logic [PAYLOAD_W-1:0] win_payload
);

    logic is_cfg;
    logic is_win;

    always_comb begin
        is_cfg = (p2d_cmd.opcode == OP_CONFIG);
        is_win = (p2d_cmd.opcode == OP_WINDOW);
    end

    always_comb begin
        cfg_valid   = p2d_valid && is_cfg;
        win_valid   = p2d_valid && is_win;
        win_payload = p2d_cmd.payload;
    end

    // window and unknown words never stall, unknown ones are dropped here
    always_comb begin
        if (is_cfg) begin
            p2d_ready = cfg_ready;
        end else begin
            p2d_ready = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/stream_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_slice import dd_pkg::*; #(
    parameter type payload_t = cmd_word_t
) (
    input  logic     ui_clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     skid_valid;
    payload_t skid_data;

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else if (out_ready || !out_valid) begin
            // output slot free, drain the skid entry first
            if (skid_valid) begin
                out_valid  <= 1'b1;
                out_data   <= skid_data;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_valid && in_ready;
                out_data  <= in_data;
            end
            in_ready <= 1'b1;
        end else if (in_valid && in_ready) begin
            // output stalled, park the word
            skid_valid <= 1'b1;
            skid_data  <= in_data;
            in_ready   <= 1'b0;
        end else begin
            in_ready <= !skid_valid;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dd_pkg.sv ====
`default_nettype none

package dd_pkg;

    // command word layout
    localparam int OPCODE_W  = 15;
    localparam int PAYLOAD_W = 17;

    localparam logic [OPCODE_W-1:0] OP_CONFIG     = 15'd1;
    localparam logic [OPCODE_W-1:0] OP_TRAIN_DONE = 15'd2;
    localparam logic [OPCODE_W-1:0] OP_DRAM_READY = 15'd3;
    localparam logic [OPCODE_W-1:0] OP_WINDOW     = 15'd4;
    localparam logic [OPCODE_W-1:0] OP_WRITE_DONE = 15'd5;
    localparam logic [OPCODE_W-1:0] OP_PROGRESS   = 15'd6;

    // configuration sequence
    localparam int CONFIG_WORDS  = 39;
    localparam int CONFIG_FIELDS = 9;
    localparam int CONFIG_CNT_W  = $clog2(CONFIG_WORDS + 1);

    // ddr user interface
    localparam int DRAM_DATA_W   = 256;
    localparam int APP_ADDR_W    = 29;
    localparam int APP_MASK_W    = DRAM_DATA_W / 8;
    localparam int WIN_ADDR_W    = 32;
    localparam int ADDR_STEP     = 8;
    localparam int PROGRESS_STEP = 10000;
    localparam int PROG_CNT_W    = $clog2(PROGRESS_STEP + 1);

    localparam logic [2:0] APP_CMD_WRITE = 3'b000;

    typedef struct packed {
        logic [PAYLOAD_W-1:0] payload;
        logic [OPCODE_W-1:0]  opcode;
    } cmd_word_t;

    typedef logic [DRAM_DATA_W-1:0] dram_word_t;

    typedef struct packed {
        logic                  en;
        logic [2:0]            cmd;
        logic [APP_ADDR_W-1:0] addr;
        logic                  wdf_wren;
        dram_word_t            wdf_data;
        logic                  wdf_end;
        logic [APP_MASK_W-1:0] wdf_mask;
    } app_write_t;

    typedef struct packed {
        logic [1:0]  asic_mode;
        logic [15:0] training_epochs;
        logic [15:0] inference_epochs;
        logic [1:0]  dataset;
        logic [15:0] timesteps;
        logic [15:0] input_size;
        logic        long_streaming;
        logic        binary_classifier;
        logic        loser_encourage;
    } asic_config_t;

endpackage

`default_nettype wire
